//--- hw/soc_pkg.sv
package soc_pkg;

  localparam int ADDR_W = 32;                  // bus address width.
  localparam int DATA_W = 32;                  // bus data width.
  localparam int SEL_W = DATA_W / 8;           // one select bit per byte lane.
  localparam int WORD_LSB = $clog2(SEL_W);     // address bits below this pick a byte.

  // The top nibble of the address selects the region.
  localparam int REGION_W = 4;                           // width of the region field.
  localparam logic [REGION_W-1:0] ROM_REGION = 4'h0;     // boot ROM lives at the bottom.
  localparam logic [REGION_W-1:0] IO_REGION = 4'h3;      // timer block, supervisor only.
  localparam logic [REGION_W-1:0] RAM_REGION = 4'hc;     // general purpose RAM.

  localparam int RAM_WORDS = 64;                    // RAM depth in words.
  localparam int ROM_WORDS = 8;                     // ROM depth in words.
  localparam int RAM_IDX_W = $clog2(RAM_WORDS);     // RAM word index width.
  localparam int ROM_IDX_W = $clog2(ROM_WORDS);     // ROM word index width, so addresses wrap.

  localparam int NUM_TIMERS = 4;     // interval timers in the I/O block.
  localparam int IO_IDX_W = 4;       // I/O word index covers offsets 0 to 15.

  // Word offsets of the timer registers inside the I/O region.
  localparam logic [IO_IDX_W-1:0] TMR_CTRL = 4'd0;       // enable bits, one per timer.
  localparam logic [IO_IDX_W-1:0] TMR_STATUS = 4'd1;     // pending bits, write one to clear.
  localparam logic [IO_IDX_W-1:0] TMR_CMP_BASE = 4'd4;   // compare registers at 4 to 7.
  localparam logic [IO_IDX_W-1:0] TMR_CNT_BASE = 4'd8;   // read-only counters at 8 to 11.

  typedef enum logic [1:0] {
    CS_ROM,      // access goes to the boot ROM.
    CS_RAM,      // access goes to the RAM.
    CS_IO,       // access goes to the timer block.
    CS_NONE      // rejected, the MMU answers with a fault.
  } cs_t;

  // Boot image, a short fixed program that the ROM hands back word by word.
  localparam logic [DATA_W-1:0] BIOS_IMAGE [ROM_WORDS] = '{
    32'h3c1d_c000,
    32'h27bd_00fc,
    32'h3c08_3000,
    32'h2409_0040,
    32'had09_0010,
    32'h2409_0005,
    32'had09_0000,
    32'h0800_0007
  };

endpackage

//--- hw/exc_pkg.sv
package exc_pkg;

  localparam int NUM_IRQ_SRC = 5;   // the MMU fault plus four timer levels.

  // Exception codes seen by the processor, codes 1 and 6 stay free for a UART.
  typedef enum logic [3:0] {
    EXC_RESET  = 4'd0,   // nothing pending, also the value when interrupts are off.
    EXC_TIMER0 = 4'd2,   // timer 0 reached its compare value.
    EXC_TIMER1 = 4'd3,   // timer 1 reached its compare value.
    EXC_TIMER2 = 4'd4,   // timer 2 reached its compare value.
    EXC_TIMER3 = 4'd5,   // timer 3 reached its compare value.
    EXC_MMU    = 4'd7    // the MMU rejected the current access.
  } exc_t;

endpackage

//--- hw/if_wb.sv
`timescale 1ns/1ps

interface if_wb import soc_pkg::*; ();

  logic              cyc;     // bus cycle in progress.
  logic              stb;     // strobe, valid transfer request.
  logic              we;      // high for a write.
  logic [SEL_W-1:0]  sel;     // byte lane selects.
  logic [ADDR_W-1:0] adr;     // byte address.
  logic [DATA_W-1:0] dat_w;   // write data from the master.
  logic [DATA_W-1:0] dat_r;   // read data from the slave, valid with ack.
  logic              ack;     // one-cycle acknowledge from the slave.

  modport master (
    output cyc, stb, we, sel, adr, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, sel, adr, dat_w,
    output dat_r, ack
  );

endinterface

//--- hw/mmu.sv
`timescale 1ns/1ps

module mmu import soc_pkg::*; (
  input  logic clk_i,          // system clock.
  input  logic rst_n_i,        // synchronous reset, active low.
  if_wb.slave  cpubus,         // requests from the processor side.
  if_wb.master rombus,         // towards the boot ROM.
  if_wb.master rambus,         // towards the RAM.
  if_wb.master iobus,          // towards the timer block.
  input  logic supervisor_i,   // processor runs in supervisor mode.
  output logic fault_o         // one-cycle pulse with the ack of a rejected access.
);

  logic [REGION_W-1:0] region;   // top address nibble.
  cs_t                 cs;       // chip select after the access checks.
  logic                req;      // a transfer is requested on the cpu side.
  logic                flt_ack;  // locally generated acknowledge for rejected accesses.

  assign region = cpubus.adr[ADDR_W-1 -: REGION_W];   // region field of the address.
  assign req = cpubus.cyc && cpubus.stb;              // valid request this cycle.

  // Decode the region and apply the protection rules.
  always_comb
  begin
    cs = CS_NONE;                       // unmapped regions fall through to a fault.
    case (region)
      ROM_REGION:
        if (!cpubus.we)
          cs = CS_ROM;                  // the ROM only takes reads.
      RAM_REGION:
        cs = CS_RAM;                    // RAM is open in either mode.
      IO_REGION:
        if (supervisor_i)
          cs = CS_IO;                   // user code may not touch the timers.
      default:
        cs = CS_NONE;
    endcase
  end

  // Address, data and controls go to every slave, only the strobe is steered.
  assign rombus.cyc = cpubus.cyc;
  assign rombus.we = cpubus.we;
  assign rombus.sel = cpubus.sel;
  assign rombus.adr = cpubus.adr;
  assign rombus.dat_w = cpubus.dat_w;
  assign rombus.stb = cpubus.stb && (cs == CS_ROM);   // ROM sees only its own accesses.

  assign rambus.cyc = cpubus.cyc;
  assign rambus.we = cpubus.we;
  assign rambus.sel = cpubus.sel;
  assign rambus.adr = cpubus.adr;
  assign rambus.dat_w = cpubus.dat_w;
  assign rambus.stb = cpubus.stb && (cs == CS_RAM);   // a rejected access never reaches RAM.

  assign iobus.cyc = cpubus.cyc;
  assign iobus.we = cpubus.we;
  assign iobus.sel = cpubus.sel;
  assign iobus.adr = cpubus.adr;
  assign iobus.dat_w = cpubus.dat_w;
  assign iobus.stb = cpubus.stb && (cs == CS_IO);     // timers only in supervisor mode.

  // Rejected accesses still need an acknowledge one cycle after the strobe.
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      flt_ack <= 1'b0;                                  // no fault pending out of reset.
    else
      flt_ack <= req && (cs == CS_NONE) && !flt_ack;    // single-cycle pulse per access.
  end

  assign fault_o = flt_ack;   // the fault pulse is the local ack itself.

  // The address is held until ack, so the select still points at the right slave.
  always_comb
  begin
    case (cs)
      CS_ROM:
      begin
        cpubus.ack = rombus.ack;       // ROM answer.
        cpubus.dat_r = rombus.dat_r;
      end
      CS_RAM:
      begin
        cpubus.ack = rambus.ack;       // RAM answer.
        cpubus.dat_r = rambus.dat_r;
      end
      CS_IO:
      begin
        cpubus.ack = iobus.ack;        // timer block answer.
        cpubus.dat_r = iobus.dat_r;
      end
      default:
      begin
        cpubus.ack = flt_ack;          // faults read back as zero.
        cpubus.dat_r = '0;
      end
    endcase
  end

endmodule

//--- hw/bios_rom.sv
`timescale 1ns/1ps

module bios_rom import soc_pkg::*; (
  input logic clk_i,      // system clock.
  input logic rst_n_i,    // synchronous reset, active low.
  if_wb.slave rombus      // read-only port, writes are filtered by the MMU.
);

  logic [ROM_IDX_W-1:0] idx;      // word index, upper address bits are dropped.
  logic                 access;   // new request that has not been acknowledged.

  assign idx = rombus.adr[WORD_LSB +: ROM_IDX_W];                 // wraps every eight words.
  assign access = rombus.cyc && rombus.stb && !rombus.ack;        // one ack per request.

  // The acknowledge is control state and starts low.
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      rombus.ack <= 1'b0;       // idle after reset.
    else
      rombus.ack <= access;     // registered one cycle after the strobe.
  end

  // Read data is loaded together with the acknowledge.
  always_ff @(posedge clk_i)
  begin
    if (access)
      rombus.dat_r <= BIOS_IMAGE[idx];   // word straight out of the boot image.
  end

endmodule

//--- hw/ram_block.sv
`timescale 1ns/1ps

module ram_block import soc_pkg::*; (
  input logic clk_i,      // system clock.
  input logic rst_n_i,    // synchronous reset, active low.
  if_wb.slave rambus      // byte-writable word port.
);

  logic [DATA_W-1:0]    mem [RAM_WORDS];   // storage array, contents undefined at power up.
  logic [RAM_IDX_W-1:0] idx;               // word index from the address.
  logic                 access;            // request waiting for its ack.

  assign idx = rambus.adr[WORD_LSB +: RAM_IDX_W];                 // bits above the byte offset.
  assign access = rambus.cyc && rambus.stb && !rambus.ack;        // first cycle of the request.

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      rambus.ack <= 1'b0;       // nothing outstanding after reset.
    else
      rambus.ack <= access;     // answer on the next edge, exactly once.
  end

  // Writes and reads both land on the edge that raises the ack.
  always_ff @(posedge clk_i)
  begin
    if (access)
    begin
      if (rambus.we)
      begin
        for (int b = 0; b < SEL_W; b++)
        begin
          if (rambus.sel[b])
            mem[idx][8*b +: 8] <= rambus.dat_w[8*b +: 8];   // only the selected lanes change.
        end
      end
      rambus.dat_r <= mem[idx];   // full word, a write returns the old contents.
    end
  end

endmodule

//--- hw/io_timers.sv
`timescale 1ns/1ps

module io_timers import soc_pkg::*; (
  input  logic                  clk_i,         // system clock.
  input  logic                  rst_n_i,       // synchronous reset, active low.
  if_wb.slave                   iobus,         // register port for supervisor accesses.
  output logic [NUM_TIMERS-1:0] timer_irq_o    // one pending level per timer.
);

  logic [NUM_TIMERS-1:0] enable;             // counter run bits.
  logic [NUM_TIMERS-1:0] pending;            // set when a counter meets its compare.
  logic [NUM_TIMERS-1:0] hit;                // counter equals compare on this edge.
  logic [DATA_W-1:0]     cmp [NUM_TIMERS];   // compare values.
  logic [DATA_W-1:0]     cnt [NUM_TIMERS];   // free running counters.
  logic [IO_IDX_W-1:0]   idx;                // register word offset.
  logic                  access;             // request not yet acknowledged.
  logic                  wr;                 // register write on this edge.
  logic [DATA_W-1:0]     rd_word;            // read mux output.

  assign idx = iobus.adr[WORD_LSB +: IO_IDX_W];                // offset inside the I/O region.
  assign access = iobus.cyc && iobus.stb && !iobus.ack;        // one ack per request.
  assign wr = access && iobus.we;                              // writes commit with the ack.
  assign timer_irq_o = pending;                                // levels go straight out.

  always_comb
  begin
    for (int t = 0; t < NUM_TIMERS; t++)
      hit[t] = enable[t] && (cnt[t] == cmp[t]);   // a stopped timer never matches.
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      iobus.ack <= 1'b0;
      enable <= '0;                  // all timers stopped.
      pending <= '0;                 // no interrupts pending.
      for (int t = 0; t < NUM_TIMERS; t++)
      begin
        cnt[t] <= '0;
        cmp[t] <= '0;
      end
    end
    else
    begin
      iobus.ack <= access;           // answer one cycle after the strobe.
      for (int t = 0; t < NUM_TIMERS; t++)
      begin
        if (hit[t])
          cnt[t] <= '0;              // wrap at the compare value.
        else if (enable[t])
          cnt[t] <= cnt[t] + DATA_W'(1);   // count every cycle while enabled.
        if (wr && idx == TMR_CMP_BASE + IO_IDX_W'(t))
        begin
          for (int b = 0; b < SEL_W; b++)
          begin
            if (iobus.sel[b])
              cmp[t][8*b +: 8] <= iobus.dat_w[8*b +: 8];   // byte writable compare.
          end
        end
      end
      if (wr && idx == TMR_CTRL && iobus.sel[0])
        enable <= iobus.dat_w[NUM_TIMERS-1:0];             // enables sit in the low byte.
      // A new match wins over a clear that happens on the same edge.
      if (wr && idx == TMR_STATUS && iobus.sel[0])
        pending <= (pending & ~iobus.dat_w[NUM_TIMERS-1:0]) | hit;
      else
        pending <= pending | hit;
    end
  end

  always_comb
  begin
    rd_word = '0;                                           // unused offsets read zero.
    if (idx == TMR_CTRL)
      rd_word[NUM_TIMERS-1:0] = enable;
    if (idx == TMR_STATUS)
      rd_word[NUM_TIMERS-1:0] = pending;
    for (int t = 0; t < NUM_TIMERS; t++)
    begin
      if (idx == TMR_CMP_BASE + IO_IDX_W'(t))
        rd_word = cmp[t];
      if (idx == TMR_CNT_BASE + IO_IDX_W'(t))
        rd_word = cnt[t];                                   // counter value at request time.
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (access)
      iobus.dat_r <= rd_word;   // captured with the ack.
  end

endmodule

//--- hw/irq_encoder.sv
`timescale 1ns/1ps

module irq_encoder import soc_pkg::*; import exc_pkg::*; (
  input  logic                  int_en_i,      // interrupts enabled by the processor.
  input  logic                  fault_i,       // MMU fault pulse.
  input  logic [NUM_TIMERS-1:0] timer_irq_i,   // timer pending levels.
  output exc_t                  exc_o          // exception code for the processor.
);

  logic [NUM_IRQ_SRC-1:0] src;   // all sources, fault in the top bit.

  assign src = {fault_i, timer_irq_i};   // fault outranks every timer.

  always_comb
  begin
    exc_o = EXC_RESET;                    // code zero while interrupts are disabled.
    if (int_en_i)
    begin
      casez (src)
        5'b1????: exc_o = EXC_MMU;        // a rejected access comes first.
        5'b01???: exc_o = EXC_TIMER3;     // higher timer numbers win.
        5'b001??: exc_o = EXC_TIMER2;
        5'b0001?: exc_o = EXC_TIMER1;
        5'b00001: exc_o = EXC_TIMER0;
        default:  exc_o = EXC_RESET;      // nothing pending.
      endcase
    end
  end

endmodule

//--- hw/soc.sv
`timescale 1ns/1ps

module soc import soc_pkg::*; (
  input  logic              clk_i,             // system clock.
  input  logic              rst_n_i,           // synchronous reset, active low.
  input  logic              cpu_cyc_i,         // processor bus cycle.
  input  logic              cpu_stb_i,         // processor strobe.
  input  logic              cpu_we_i,          // processor write enable.
  input  logic [SEL_W-1:0]  cpu_sel_i,         // processor byte selects.
  input  logic [ADDR_W-1:0] cpu_adr_i,         // processor byte address.
  input  logic [DATA_W-1:0] cpu_dat_i,         // processor write data.
  output logic [DATA_W-1:0] cpu_dat_o,         // read data back to the processor.
  output logic              cpu_ack_o,         // acknowledge back to the processor.
  input  logic              supervisor_i,      // processor privilege level.
  input  logic              int_en_i,          // processor interrupt enable.
  output logic [3:0]        cpu_interrupt_o,   // encoded exception code.
  output logic              mmu_fault_o        // rejected access pulse.
);

  if_wb cpubus();   // processor side of the MMU.
  if_wb rombus();   // MMU to boot ROM.
  if_wb rambus();   // MMU to RAM.
  if_wb iobus();    // MMU to the timer block.

  logic [NUM_TIMERS-1:0] timer_irq;   // timer levels, only visible through the encoder.
  logic                  fault;       // MMU fault pulse.

  // Plain processor ports onto the internal bus.
  assign cpubus.cyc = cpu_cyc_i;
  assign cpubus.stb = cpu_stb_i;
  assign cpubus.we = cpu_we_i;
  assign cpubus.sel = cpu_sel_i;
  assign cpubus.adr = cpu_adr_i;
  assign cpubus.dat_w = cpu_dat_i;
  assign cpu_dat_o = cpubus.dat_r;
  assign cpu_ack_o = cpubus.ack;
  assign mmu_fault_o = fault;         // the same pulse also feeds the encoder.

  mmu mmu0 (.clk_i(clk_i), .rst_n_i(rst_n_i),
            .cpubus(cpubus.slave),
            .rombus(rombus.master),
            .rambus(rambus.master),
            .iobus(iobus.master),
            .supervisor_i(supervisor_i),
            .fault_o(fault));

  bios_rom bios0 (.clk_i(clk_i), .rst_n_i(rst_n_i),
                  .rombus(rombus.slave));

  ram_block ram0 (.clk_i(clk_i), .rst_n_i(rst_n_i),
                  .rambus(rambus.slave));

  io_timers io0 (.clk_i(clk_i), .rst_n_i(rst_n_i),
                 .iobus(iobus.slave),
                 .timer_irq_o(timer_irq));

  irq_encoder irq0 (.int_en_i(int_en_i),
                    .fault_i(fault),
                    .timer_irq_i(timer_irq),
                    .exc_o(cpu_interrupt_o));

endmodule

//--- tests/soc_asserts.sv
`timescale 1ns/1ps

module soc_asserts import exc_pkg::*; (
  input logic        clk_i,         // system clock.
  input logic        rst_n_i,       // synchronous reset, active low.
  input logic        cyc_i,         // processor bus cycle.
  input logic        stb_i,         // processor strobe.
  input logic        ack_i,         // acknowledge back to the processor.
  input logic [31:0] dat_i,         // read data back to the processor.
  input logic        fault_i,       // MMU fault pulse.
  input logic        int_en_i,      // interrupt enable.
  input logic [3:0]  exc_i,         // encoded exception code.
  input logic [3:0]  timer_irq_i    // timer pending levels inside the top level.
);

  int err_count = 0;   // number of failed assertions so far.

  // The fault comes first, then the highest numbered timer.
  function automatic logic [3:0] expected_exc(input logic en, input logic flt,
                                              input logic [3:0] tmr);
    if (!en)
      return 4'(EXC_RESET);
    if (flt)
      return 4'(EXC_MMU);
    if (tmr[3])
      return 4'(EXC_TIMER3);
    if (tmr[2])
      return 4'(EXC_TIMER2);
    if (tmr[1])
      return 4'(EXC_TIMER1);
    if (tmr[0])
      return 4'(EXC_TIMER0);
    return 4'(EXC_RESET);
  endfunction

  ack_timing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cyc_i && stb_i && !ack_i) |=> ack_i)
    else begin $error("ack did not arrive one cycle after the strobe"); err_count++; end

  ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i) ack_i |=> !ack_i)
    else begin $error("ack stayed high for more than one cycle"); err_count++; end

  fault_with_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fault_i |-> (ack_i && dat_i == 32'h0))
    else begin $error("fault pulse without ack or with nonzero data"); err_count++; end

  irq_priority: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    exc_i == expected_exc(int_en_i, fault_i, timer_irq_i))
    else begin $error("interrupt code breaks the priority rule"); err_count++; end

  reset_idle: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> (!ack_i && !fault_i && exc_i == 4'h0 && timer_irq_i == 4'h0))
    else begin $error("bus or interrupt active right after reset"); err_count++; end

endmodule

bind soc soc_asserts soc_asserts_i (
  .clk_i(clk_i),
  .rst_n_i(rst_n_i),
  .cyc_i(cpu_cyc_i),
  .stb_i(cpu_stb_i),
  .ack_i(cpu_ack_o),
  .dat_i(cpu_dat_o),
  .fault_i(mmu_fault_o),
  .int_en_i(int_en_i),
  .exc_i(cpu_interrupt_o),
  .timer_irq_i(timer_irq)
);

//--- tests/tb_soc.sv
`timescale 1ns/1ps

module tb_soc import soc_pkg::*; import exc_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 6000;   // well beyond the few hundred cycles the tests need.
  localparam int POLL_LIMIT = 100;        // status reads before a timer counts as stuck.

  logic              clk_i;
  logic              rst_n_i;
  logic              cpu_cyc_i;
  logic              cpu_stb_i;
  logic              cpu_we_i;
  logic [SEL_W-1:0]  cpu_sel_i;
  logic [ADDR_W-1:0] cpu_adr_i;
  logic [DATA_W-1:0] cpu_dat_i;
  logic [DATA_W-1:0] cpu_dat_o;
  logic              cpu_ack_o;
  logic              supervisor_i;
  logic              int_en_i;
  logic [3:0]        cpu_interrupt_o;
  logic              mmu_fault_o;

  logic [DATA_W-1:0] shadow [RAM_WORDS];   // expected RAM contents.
  logic [31:0]       lcg_state;            // state of the random generator.
  int                cycle_count;          // clock edges since time zero.
  logic [DATA_W-1:0] rdat;                 // read data of the last access.
  logic              flt;                  // fault flag seen with the last ack.
  logic [3:0]        irq;                  // exception code seen with the last ack.

  soc soc_i (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;   // 10 ns period.
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;   // classic 32-bit LCG step.
    return lcg_state;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] upd,
                                             input logic [3:0] sel);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++)
      if (sel[b])
        res[8*b +: 8] = upd[8*b +: 8];   // selected lanes take the new byte.
    return res;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] adr);
    return (adr * 32'h9e37_79b9) ^ 32'h5a5a_c3c3;   // every address bit changes the pattern.
  endfunction

  function automatic logic [31:0] rom_addr(input logic [3:0] i);
    return {ROM_REGION, 22'h0, i, 2'b00};
  endfunction

  function automatic logic [31:0] ram_addr(input logic [5:0] i);
    return {RAM_REGION, 20'h0, i, 2'b00};
  endfunction

  function automatic logic [31:0] io_addr(input logic [3:0] off);
    return {IO_REGION, 22'h0, off, 2'b00};
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp)
    else
    begin
      $display("[ERROR] %s expected %h actual %h", name, exp, got);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  // Run one bus access and hold the strobe until the ack is seen.
  task automatic bus_access(input logic we, input logic [3:0] sel, input logic [31:0] adr,
                            input logic [31:0] wdat);
    @(posedge clk_i);
    cpu_cyc_i <= 1'b1;
    cpu_stb_i <= 1'b1;
    cpu_we_i <= we;
    cpu_sel_i <= sel;
    cpu_adr_i <= adr;
    cpu_dat_i <= wdat;
    @(negedge clk_i);
    while (!cpu_ack_o)
      @(negedge clk_i);          // outputs are settled at the falling edge.
    rdat = cpu_dat_o;
    flt = mmu_fault_o;
    irq = cpu_interrupt_o;
    @(posedge clk_i);
    cpu_cyc_i <= 1'b0;
    cpu_stb_i <= 1'b0;
    cpu_we_i <= 1'b0;
  endtask

  task automatic set_mode(input logic sup, input logic en);
    @(posedge clk_i);
    supervisor_i <= sup;
    int_en_i <= en;
  endtask

  task automatic expect_irq(input string name, input exc_t exp);
    @(negedge clk_i);
    check_value(name, 32'(exp), 32'(cpu_interrupt_o));
  endtask

  task automatic expect_fault(input string name, input logic we, input logic [31:0] adr);
    bus_access(we, 4'hf, adr, 32'hffff_ffff);
    check_value({name, "_data"}, 32'h0, rdat);        // rejected accesses read zero.
    check_value({name, "_pulse"}, 32'h1, 32'(flt));
    check_value({name, "_irq"}, 32'(EXC_MMU), 32'(irq));
  endtask

  // Watchdog and collector for the bound assertions.
  initial
  begin
    cycle_count = 0;
    forever
    begin
      @(posedge clk_i);
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
        $display("timeout after %0d cycles, the tests did not finish", cycle_count);
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
      end
      else if (soc_i.soc_asserts_i.err_count != 0)
      begin
        $display("a bus or interrupt assertion failed at cycle %0d", cycle_count);
        $display("STATUS: FAIL");
        $fatal(1, "assertion failure");
      end
    end
  end

  initial
  begin
    cs_t         kind;
    logic [31:0] r;
    logic [31:0] word;
    logic [5:0]  idx;
    int          polls;
    cpu_cyc_i = 1'b0;
    cpu_stb_i = 1'b0;
    cpu_we_i = 1'b0;
    cpu_sel_i = '0;
    cpu_adr_i = '0;
    cpu_dat_i = '0;
    supervisor_i = 1'b1;
    int_en_i = 1'b1;               // enabled so a stray code would show up.
    rst_n_i = 1'b0;
    lcg_state = 32'h1133_4f9d;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_value("reset_ack", 32'h0, 32'(cpu_ack_o));
    check_value("reset_fault", 32'h0, 32'(mmu_fault_o));
    check_value("reset_irq", 32'h0, 32'(cpu_interrupt_o));
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;               // low for four rising edges.

    kind = CS_ROM;
    for (int m = 0; m < 2; m++)
    begin
      set_mode(m == 0, 1'b1);      // supervisor first, then user.
      for (int i = 0; i < ROM_WORDS; i++)
      begin
        bus_access(1'b0, 4'hf, rom_addr(4'(i)), 32'h0);
        check_value($sformatf("%s_read_m%0d[%0d]", kind.name(), m, i), BIOS_IMAGE[3'(i)], rdat);
      end
    end
    bus_access(1'b0, 4'hf, rom_addr(4'd9), 32'h0);   // index nine wraps onto word one.
    check_value("rom_wrap", BIOS_IMAGE[1], rdat);
    set_mode(1'b1, 1'b1);

    for (int n = 0; n < RAM_WORDS; n++)
    begin
      word = fill_word(ram_addr(6'(n)));
      bus_access(1'b1, 4'hf, ram_addr(6'(n)), word);
      shadow[n] = word;
    end
    for (int n = 0; n < 40; n++)
    begin
      r = next_random();
      idx = r[13:8];
      word = next_random();
      bus_access(1'b1, r[3:0], ram_addr(idx), word);
      shadow[idx] = merge_bytes(shadow[idx], word, r[3:0]);
    end
    for (int n = 0; n < RAM_WORDS; n++)
    begin
      bus_access(1'b0, 4'hf, ram_addr(6'(n)), 32'h0);
      check_value($sformatf("ram_read[%0d]", n), shadow[n], rdat);
    end

    expect_fault("unmapped_read", 1'b0, 32'h5000_0040);
    expect_fault("rom_write", 1'b1, rom_addr(4'd2));
    expect_fault("ram_alias_write", 1'b1, 32'hd000_0044);   // same low bits as RAM word 17.
    bus_access(1'b0, 4'hf, ram_addr(6'd17), 32'h0);
    check_value("ram_after_alias", shadow[17], rdat);
    set_mode(1'b0, 1'b1);
    expect_fault("user_io_read", 1'b0, io_addr(TMR_CTRL));
    expect_fault("user_io_write", 1'b1, io_addr(TMR_CTRL));
    set_mode(1'b1, 1'b1);
    bus_access(1'b0, 4'hf, io_addr(TMR_CTRL), 32'h0);
    check_value("ctrl_after_user_write", 32'h0, rdat);

    bus_access(1'b1, 4'hf, io_addr(TMR_CMP_BASE), 32'd20);
    bus_access(1'b1, 4'hf, io_addr(TMR_CMP_BASE + 4'd2), 32'd45);
    bus_access(1'b1, 4'hf, io_addr(TMR_CTRL), 32'h5);   // start timers 0 and 2.
    polls = 0;
    rdat = '0;
    while ((rdat & 32'h5) != 32'h5)
    begin
      if (polls == POLL_LIMIT)
      begin
        $display("timer pending bits never set, status %h after %0d reads", rdat, polls);
        $display("STATUS: FAIL");
        $fatal(1, "timer stuck");
      end
      bus_access(1'b0, 4'hf, io_addr(TMR_STATUS), 32'h0);
      polls++;
    end
    bus_access(1'b1, 4'hf, io_addr(TMR_CTRL), 32'h0);   // freeze so nothing re-pends.
    bus_access(1'b0, 4'hf, io_addr(TMR_STATUS), 32'h0);
    check_value("timer_status", 32'h5, rdat);
    expect_irq("irq_both_pending", EXC_TIMER2);
    set_mode(1'b1, 1'b0);
    expect_irq("irq_disabled_both", EXC_RESET);
    set_mode(1'b1, 1'b1);
    bus_access(1'b1, 4'h1, io_addr(TMR_STATUS), 32'h4);
    expect_irq("irq_after_clear2", EXC_TIMER0);
    set_mode(1'b1, 1'b0);
    expect_irq("irq_disabled_timer0", EXC_RESET);
    set_mode(1'b1, 1'b1);
    bus_access(1'b1, 4'h1, io_addr(TMR_STATUS), 32'h1);
    expect_irq("irq_after_clear0", EXC_RESET);

    repeat (3) @(posedge clk_i);   // let the last assertions sample.
    if (soc_i.soc_asserts_i.err_count == 0)
    begin
      $display("STATUS: PASS");
      $finish;
    end
    else
    begin
      $display("%0d assertion failures were recorded", soc_i.soc_asserts_i.err_count);
      $display("STATUS: FAIL");
      $fatal(1, "assertion failures");
    end
  end

endmodule

//--- vlog.f
hw/soc_pkg.sv
hw/exc_pkg.sv
hw/if_wb.sv
hw/mmu.sv
hw/bios_rom.sv
hw/ram_block.sv
hw/io_timers.sv
hw/irq_encoder.sv
hw/soc.sv
tests/soc_asserts.sv
tests/tb_soc.sv

//--- run.sh
#!/bin/sh
# Compile and run the SoC testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_soc -f vlog.f -o tb_soc_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/tb_soc_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
